/* list.f */
cpc_mem_pkg.sv
cpc_mf2_pkg.sv
load_control.sv
ext_page_decode.sv
boot_addr_map.sv
mf2_paging.sv
mf2_store.sv
cpc_loader_top.sv
tb_clock.sv
cpc_loader_checker.sv
tb_cpc_loader.sv
+incdir+.

/* run.sh */
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	--top-module tb_cpc_loader \
	-f list.f \
	-o sim_cpc_loader

./obj_dir/sim_cpc_loader | tee sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	exit 1
fi
exit 0

/* tb_cpc_loader.sv */
// Random stimulus, reference model, checks and final report for the loader top level
`timescale 1ns/1ps
`include "cpc_defs.svh"

module tb_cpc_loader;

	localparam int ROM_WRITES   = 40;
	localparam int EXT_LOADS    = 8;
	localparam int EXT_WRITES   = 10;
	localparam int COMBO_WRITES = 12;
	localparam int STORE_IO     = 30;
	localparam int STORE_MEM    = 30;
	localparam int TEST_CYCLES  = (ROM_WRITES * 2 + 10) + EXT_LOADS * (EXT_WRITES * 2 + 10)
		+ (COMBO_WRITES * 2 + 10) + 3 * 60 + (STORE_IO + STORE_MEM * 3) * 2 + 30;
	localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

	logic clk_sys, reset, ioctl_download, ioctl_wr, reset_req, cpc664_sel;
	logic [7:0] ioctl_index, ioctl_dout, cpu_dout, boot_dout, mf2_dout;
	logic [15:0] ioctl_file_ext, cpu_addr;
	logic [`CPC_IOCTL_AW-1:0] ioctl_addr;
	logic [1:0] mf2_mode, boot_bank;
	logic key_nmi, m1_start, io_wr, mem_wr, mem_rd, core_reset, model, boot_wr;
	logic mf2_nmi, mf2_en, mf2_rom_en, mf2_ram_en;
	logic [`CPC_ROM_MAP_N-1:0] rom_map;
	cpc_mem_pkg::boot_addr_u boot_addr;

	// Reference model state
	logic [31:0] seed = 32'h937dae4f;
	logic [31:0] r;
	logic [255:0] exp_map;
	logic exp_model, m_nmi, m_en, m_hidden;
	logic [7:0] m_ram [0:8191];
	logic [4:0] m_pen;
	logic [3:0] m_crtc;
	int wr_q[$];
	int value_errors = 0;
	int cycles = 0;

	tb_clock i_tb_clock (.clk_sys, .reset);
	cpc_loader_top i_cpc_loader_top (.*);

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Errors: %0d value, run stopped after %0d cycles without finishing",
				value_errors, cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] hex_char(input logic [3:0] d);
		return (d < 4'd10) ? 8'("0") + 8'(d) : 8'("A") + 8'(d) - 8'd10;
	endfunction

	task automatic next_rand();
		seed = lcg_next(seed);
		r = seed;
	endtask

	task automatic check_val(input string name, input logic [255:0] got, input logic [255:0] exp);
		assert (got === exp) else begin
			value_errors++;
			$display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////
	// Host download side
	task automatic start_download(input logic [7:0] idx, input logic [15:0] ext);
		next_rand();
		cpc664_sel = r[20];
		exp_model = r[20];		// Latched while the core is in reset
		ioctl_index = idx;
		ioctl_file_ext = ext;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_val("core_reset", 256'(core_reset), 256'(1'b0));
		check_val("model", 256'(model), 256'(exp_model));
	endtask

	task automatic write_boot(input logic [24:0] addr, input logic exp_wr,
			input logic [22:0] exp_addr, input logic [1:0] exp_bank);
		next_rand();
		ioctl_addr = addr;
		ioctl_dout = r[31:24];
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check_val("boot_wr", 256'(boot_wr), 256'(exp_wr));
		if (exp_wr) begin
			check_val("boot_addr", 256'(boot_addr.flat), 256'(exp_addr));
			check_val("boot_bank", 256'(boot_bank), 256'(exp_bank));
			check_val("boot_dout", 256'(boot_dout), 256'(r[31:24]));
			if (exp_addr[22])
				exp_map[exp_addr[21:14]] = 1'b1;	// Upper ROM page now loaded
		end
		check_val("rom_map", rom_map, exp_map);
		check_val("core_reset", 256'(core_reset), 256'(1'b1));
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////////////////
	// CPU side strobe followed by an idle cycle
	task automatic cpu_strobe(input logic k, m1, io, mw, mr, input logic [15:0] addr,
			input logic [7:0] data);
		logic [12:0] sa;
		logic hit;
		{key_nmi, m1_start, io_wr, mem_wr, mem_rd} = {k, m1, io, mw, mr};
		cpu_addr = addr;
		cpu_dout = data;
		@(negedge clk_sys);
		{key_nmi, m1_start, io_wr, mem_wr, mem_rd} = 5'b0;
		hit = 1'b1;
		sa = 13'd0;
		case (addr[15:8])
			8'h7F: case (data[7:6])
				2'b00: begin
					sa = `MF2_ST_PEN_IDX;
					m_pen = data[4:0];
				end
				2'b01: sa = m_pen[4] ? `MF2_ST_BORDER : {`MF2_ST_PEN_BASE, m_pen[3:0]};
				2'b10: sa = `MF2_ST_MODE;
				default: sa = `MF2_ST_BANK;
			endcase
			8'hBC: begin
				sa = `MF2_ST_CRTC_SEL;
				m_crtc = data[3:0];
			end
			8'hBD: sa = {`MF2_ST_CRTC_BASE, m_crtc};
			8'hF7: sa = `MF2_ST_PPI;
			8'hDF: sa = `MF2_ST_UROM;
			default: hit = 1'b0;
		endcase
		if (io && hit) begin
			m_ram[sa] = data;
			wr_q.push_back(int'(sa));
		end
		if (mw && m_en && addr >= 16'h2000 && addr < 16'h4000) begin
			m_ram[addr[12:0]] = data;
			wr_q.push_back(int'(addr[12:0]));
		end
		// Paging rules
		if (k && !m_en && mf2_mode != 2'd2)
			m_nmi = 1'b1;
		else if (m1 && m_nmi && addr == 16'h0066) begin
			m_en = 1'b1;
			m_hidden = 1'b0;
			m_nmi = 1'b0;
		end else if (m1 && m_en && addr == 16'h0065)
			m_hidden = 1'b1;
		else if (io && (addr & 16'hFFFD) == 16'hFEE8) begin
			m_en = !addr[1] && !m_hidden && mf2_mode != 2'd2;
			if (m_en)
				m_nmi = 1'b0;
		end
		check_val("mf2_nmi", 256'(mf2_nmi), 256'(m_nmi));
		check_val("mf2_en", 256'(mf2_en), 256'(m_en));
		@(negedge clk_sys);
	endtask

	task automatic core_reset_pulse();
		reset_req = 1'b1;
		@(negedge clk_sys);
		reset_req = 1'b0;
		repeat (2) @(negedge clk_sys);
		exp_model = cpc664_sel;
		m_en = 1'b0;
		m_nmi = 1'b0;
		m_hidden = (mf2_mode != 2'd0);
	endtask

	task automatic check_selects();
		next_rand();
		cpu_addr = r[31] ? r[15:0] : {2'b00, r[29:16]};	// Biased towards the windows
		@(negedge clk_sys);
		check_val("mf2_rom_en", 256'(mf2_rom_en), 256'(m_en && cpu_addr < 16'h2000));
		check_val("mf2_ram_en", 256'(mf2_ram_en),
			256'(m_en && cpu_addr >= 16'h2000 && cpu_addr < 16'h4000));
	endtask

	initial begin
		logic [3:0] blk;
		logic [8:0] pg, slot;
		logic [13:0] off;
		logic [15:0] ext;
		logic hv, lv;
		logic [7:0] ports [0:4];
		ports = '{8'h7F, 8'hBC, 8'hBD, 8'hF7, 8'hDF};
		{ioctl_download, ioctl_wr, reset_req, cpc664_sel} = 4'b0;
		{key_nmi, m1_start, io_wr, mem_wr, mem_rd} = 5'b0;
		ioctl_index = 8'd0;
		ioctl_dout = 8'd0;
		ioctl_file_ext = 16'd0;
		ioctl_addr = '0;
		mf2_mode = 2'd0;
		cpu_addr = 16'd0;
		cpu_dout = 8'd0;
		exp_map = '0;
		m_pen = 5'd0;
		m_crtc = 4'd0;

		@(negedge clk_sys);
		check_val("boot_wr", 256'(boot_wr), 256'(1'b0));
		check_val("mf2_nmi", 256'(mf2_nmi), 256'(1'b0));
		check_val("mf2_en", 256'(mf2_en), 256'(1'b0));
		check_val("rom_map", rom_map, 256'(0));
		check_val("core_reset", 256'(core_reset), 256'(1'b1));
		while (reset) @(negedge clk_sys);
		@(negedge clk_sys);

		////////////////////////////////////////////////////////////////////////
		// ROM download through the slot table
		start_download(`CPC_IDX_ROM, 16'd0);
		for (int i = 0; i < ROM_WRITES; i++) begin
			next_rand();
			blk = 4'(r[15:0] % 16'd10);
			off = r[29:16];
			case (blk[1:0])
				2'd0: slot = `CPC_SLOT_OS;
				2'd1: slot = `CPC_SLOT_BASIC;
				2'd2: slot = `CPC_SLOT_AMSDOS;
				default: slot = `CPC_SLOT_MF2;
			endcase
			write_boot({7'd0, blk, off}, blk < 4'd8, {slot, off}, {1'b0, blk >= 4'd4});
		end
		end_download();
		cpc664_sel = ~cpc664_sel;	// Latch holds while the core runs
		repeat (2) @(negedge clk_sys);
		check_val("model", 256'(model), 256'(exp_model));

		// Expansion pages from hex pairs, ZZ and malformed names
		for (int n = 0; n < EXT_LOADS; n++) begin
			next_rand();
			hv = r[8] || (r[1:0] == 2'd0);
			lv = (r[9] || (r[1:0] == 2'd0)) && !(r[1:0] == 2'd2 && hv);
			ext = {hv ? hex_char(r[15:12]) : 8'("G") + 8'(r[24:20] % 5'd19),
				lv ? hex_char(r[19:16]) : 8'("G") + 8'(r[29:25] % 5'd19)};
			pg = `CPC_PAGE_BAD;
			if (hv) pg[7:4] = r[15:12];
			if (lv) pg[3:0] = r[19:16];
			if (r[1:0] == 2'd1) begin
				ext = "ZZ";
				pg = 9'h000;
			end
			start_download(`CPC_IDX_EXT, ext);
			for (int i = 0; i < EXT_WRITES; i++) begin
				next_rand();
				write_boot({3'd0, r[23:16], r[13:0]}, 1'b1,
					{pg[8], pg[7:0] + r[23:16], r[13:0]}, {1'b0, exp_model});
			end
			end_download();
		end

		// Combo image switches to page 1FF after offset 3FFF
		start_download(`CPC_IDX_EXT, "Z0");
		pg = 9'h000;
		for (int i = 0; i < COMBO_WRITES; i++) begin
			next_rand();
			off = (i == COMBO_WRITES / 2) ? 14'h3FFF : r[13:0];
			if (i < COMBO_WRITES / 2 && off == 14'h3FFF)
				off = 14'h0;
			write_boot({9'd0, 2'(r[17:16]), off}, 1'b1,
				{pg[8], pg[7:0] + 8'(r[17:16]), off}, {1'b0, exp_model});
			if (off == 14'h3FFF)
				pg = `CPC_PAGE_COMBO_END;
		end
		end_download();

		////////////////////////////////////////////////////////////////////////
		// Multiface paging in each mode
		for (int m = 0; m < 3; m++) begin
			mf2_mode = 2'(m);
			core_reset_pulse();
			// Port alone pages in only when not hidden after reset
			cpu_strobe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'hFEE8, 8'h00);
			cpu_strobe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'hFEEA, 8'h00);
			cpu_strobe(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
			check_selects();
			cpu_strobe(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0066, 8'h00);
			check_selects();
			check_selects();
			cpu_strobe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'hFEEA, 8'h00);
			cpu_strobe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'hFEE8, 8'h00);
			cpu_strobe(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0065, 8'h00);
			cpu_strobe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'hFEEA, 8'h00);
			cpu_strobe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'hFEE8, 8'h00);
			check_selects();
		end

		// Register capture and Multiface RAM
		mf2_mode = 2'd0;
		core_reset_pulse();
		cpu_strobe(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
		cpu_strobe(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0066, 8'h00);
		for (int i = 0; i < STORE_IO; i++) begin
			next_rand();
			cpu_strobe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, {ports[r[15:0] % 16'd5], r[23:16]},
				r[31:24]);
		end
		for (int i = 0; i < STORE_MEM; i++) begin
			next_rand();
			cpu_strobe(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, {3'b001, r[28:16]}, r[7:0]);
		end
		foreach (wr_q[i]) begin
			cpu_strobe(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 16'h2000 | 16'(wr_q[i]), 8'h00);
			check_val("mf2_dout", 256'(mf2_dout), 256'(m_ram[wr_q[i]]));
		end

		$display("Errors: %0d value, 0 timeout", value_errors);
		if (value_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* cpc_loader_checker.sv */
// Bound assertions on Multiface paging and the boot write port
`timescale 1ns/1ps

module cpc_loader_checker (
	input logic clk_sys,
	input logic reset,
	input logic core_reset,
	input logic mf2_nmi,
	input logic mf2_en,
	input logic mf2_rom_en,
	input logic mf2_ram_en,
	input logic boot_wr
);

	// ROM and RAM windows do not overlap
	selects_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(mf2_rom_en && mf2_ram_en))
		else $error("Multiface ROM and RAM selects both high");

	nmi_or_enabled: assert property (@(posedge clk_sys) disable iff (reset)
		!(mf2_nmi && mf2_en))
		else $error("Multiface NMI pending while paged in");

	reset_pages_out: assert property (@(posedge clk_sys) disable iff (reset)
		core_reset |=> !mf2_en)
		else $error("Multiface still paged in after core reset");

	// Write strobe lasts a single cycle
	boot_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		boot_wr |=> !boot_wr)
		else $error("Boot write strobe longer than one cycle");

endmodule

bind cpc_loader_top cpc_loader_checker i_cpc_loader_checker (
	.clk_sys(clk_sys), .reset(reset), .core_reset(core_reset), .mf2_nmi(mf2_nmi),
	.mf2_en(mf2_en), .mf2_rom_en(mf2_rom_en), .mf2_ram_en(mf2_ram_en), .boot_wr(boot_wr)
);

/* tb_clock.sv */
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;	// 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

/* cpc_loader_top.sv */
// Top level of the boot image loader and the Multiface Two
`timescale 1ns/1ps
`include "cpc_defs.svh"

module cpc_loader_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	// Host download
	input  logic                      ioctl_download,
	input  logic [7:0]                ioctl_index,
	input  logic [15:0]               ioctl_file_ext,
	input  logic                      ioctl_wr,
	input  logic [`CPC_IOCTL_AW-1:0]  ioctl_addr,
	input  logic [7:0]                ioctl_dout,
	input  logic                      reset_req,
	input  logic                      cpc664_sel,
	input  logic [1:0]                mf2_mode,
	// CPU side
	input  logic                      key_nmi,
	input  logic                      m1_start,
	input  logic                      io_wr,
	input  logic                      mem_wr,
	input  logic                      mem_rd,
	input  logic [15:0]               cpu_addr,
	input  logic [7:0]                cpu_dout,
	output logic                      core_reset,
	output logic                      model,
	// Boot write port
	output logic                      boot_wr,
	output cpc_mem_pkg::boot_addr_u   boot_addr,
	output logic [1:0]                boot_bank,
	output logic [7:0]                boot_dout,
	output logic [`CPC_ROM_MAP_N-1:0] rom_map,
	// Multiface
	output logic                      mf2_nmi,
	output logic                      mf2_en,
	output logic                      mf2_rom_en,
	output logic                      mf2_ram_en,
	output logic [7:0]                mf2_dout
);

	cpc_mem_pkg::load_kind_t load_kind;
	logic                    load_start;
	logic [8:0]              page;

	load_control i_load_control (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .reset_req, .cpc664_sel,
		.load_kind, .load_start, .core_reset, .model
	);

	ext_page_decode i_ext_page_decode (
		.clk_sys, .reset, .load_start, .load_kind, .ioctl_file_ext, .ioctl_wr,
		.ioctl_offset (ioctl_addr[13:0]),
		.page
	);

	boot_addr_map i_boot_addr_map (
		.clk_sys, .reset, .load_kind, .model, .page, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.boot_wr, .boot_addr, .boot_bank, .boot_dout, .rom_map
	);

	mf2_paging i_mf2_paging (
		.clk_sys, .reset, .core_reset,
		.mf2_mode (cpc_mf2_pkg::mf2_mode_t'(mf2_mode)),
		.key_nmi, .m1_start, .io_wr, .cpu_addr,
		.mf2_nmi, .mf2_en, .mf2_rom_en, .mf2_ram_en
	);

	mf2_store i_mf2_store (
		.clk_sys, .reset, .io_wr, .mem_wr, .mem_rd, .mf2_ram_en, .cpu_addr, .cpu_dout,
		.mf2_dout
	);

endmodule

/* mf2_store.sv */
// Multiface hardware register capture decode and 8 KB Multiface RAM
`timescale 1ns/1ps
`include "cpc_defs.svh"

module mf2_store (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        io_wr,
	input  logic        mem_wr,
	input  logic        mem_rd,
	input  logic        mf2_ram_en,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dout,
	output logic [7:0]  mf2_dout
);

	cpc_mf2_pkg::store_addr_u st_addr;
	logic                     st_hit;		// Port write worth capturing
	logic [4:0]               pen_index;
	logic [3:0]               crtc_reg;
	logic                     ram_act;
	logic                     ram_we;
	logic [12:0]              ram_addr;
	logic [7:0]               ram_din;
	logic [7:0]               ram_out;
	logic [7:0]               ram [0:2**13-1];

	////////////////////////////////////////////////////////////////////////
	// Capture location of a port write
	always_comb begin
		st_addr.flat = 13'd0;
		st_hit       = 1'b1;
		case (cpu_addr[15:8])
			8'h7F: begin	// Gate array
				case (cpu_dout[7:6])
					2'b00: st_addr.flat = `MF2_ST_PEN_IDX;
					2'b01: begin
						if (pen_index[4]) begin
							st_addr.flat = `MF2_ST_BORDER;
						end else begin
							st_addr.tbl.region = `MF2_ST_PEN_BASE;
							st_addr.tbl.slot   = pen_index[3:0];
						end
					end
					2'b10: st_addr.flat = `MF2_ST_MODE;
					default: st_addr.flat = `MF2_ST_BANK;
				endcase
			end
			8'hBC: st_addr.flat = `MF2_ST_CRTC_SEL;
			8'hBD: begin
				st_addr.tbl.region = `MF2_ST_CRTC_BASE;
				st_addr.tbl.slot   = crtc_reg;
			end
			8'hF7: st_addr.flat = `MF2_ST_PPI;		// 8255
			8'hDF: st_addr.flat = `MF2_ST_UROM;
			default: st_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_act   <= 1'b0;
			ram_we    <= 1'b0;
			pen_index <= 5'd0;
			crtc_reg  <= 4'd0;
		end else begin
			ram_act <= (io_wr & st_hit) | ((mem_wr | mem_rd) & mf2_ram_en);
			ram_we  <= (io_wr & st_hit) | (mem_wr & mf2_ram_en);
			if (io_wr && cpu_addr[15:8] == 8'h7F && cpu_dout[7:6] == 2'b00)
				pen_index <= cpu_dout[4:0];
			if (io_wr && cpu_addr[15:8] == 8'hBC)
				crtc_reg <= cpu_dout[3:0];
		end
	end

	// Register capture wins over a CPU access
	always_ff @(posedge clk_sys) begin
		if (io_wr && st_hit)
			ram_addr <= st_addr.flat;
		else
			ram_addr <= cpu_addr[12:0];
		ram_din <= cpu_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (ram_act) begin
			if (ram_we) begin
				ram[ram_addr] <= ram_din;
				ram_out       <= ram_din;
			end else begin
				ram_out <= ram[ram_addr];
			end
		end
	end

	assign mf2_dout = ram_out;	// Held until the next access

endmodule

/* mf2_paging.sv */
// Multiface Two NMI request, enable and hidden state, ROM and RAM page selects
`timescale 1ns/1ps
`include "cpc_defs.svh"

module mf2_paging (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   core_reset,
	input  cpc_mf2_pkg::mf2_mode_t mf2_mode,
	input  logic                   key_nmi,
	input  logic                   m1_start,
	input  logic                   io_wr,
	input  logic [15:0]            cpu_addr,
	output logic                   mf2_nmi,
	output logic                   mf2_en,
	output logic                   mf2_rom_en,
	output logic                   mf2_ram_en
);

	logic mf2_hidden;	// Set once the exit routine ran
	logic disabled;
	logic ctrl_wr;
	logic ctrl_en;

	assign disabled = (mf2_mode == cpc_mf2_pkg::mode_disabled);
	assign ctrl_wr  = io_wr && (cpu_addr[15:2] == `MF2_CTRL_PORT);
	assign ctrl_en  = ~cpu_addr[1] & ~mf2_hidden & ~disabled;	// FEE8 in, FEEA out

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mf2_nmi    <= 1'b0;
			mf2_en     <= 1'b0;
			mf2_hidden <= 1'b0;
		end else if (core_reset) begin
			mf2_nmi    <= 1'b0;
			mf2_en     <= 1'b0;
			mf2_hidden <= (mf2_mode != cpc_mf2_pkg::mode_enabled);
		end else begin
			if (key_nmi && !mf2_en && !disabled)
				mf2_nmi <= 1'b1;	// Stop button
			if (m1_start && mf2_nmi && cpu_addr == `MF2_NMI_ADDR) begin
				mf2_en     <= 1'b1;
				mf2_hidden <= 1'b0;
				mf2_nmi    <= 1'b0;
			end
			if (m1_start && mf2_en && cpu_addr == `MF2_HIDE_ADDR)
				mf2_hidden <= 1'b1;
			if (ctrl_wr) begin
				mf2_en <= ctrl_en;
				if (ctrl_en)
					mf2_nmi <= 1'b0;	// Paged in by port, request is dropped
			end
		end
	end

	// ROM at 0000-1FFF, RAM at 2000-3FFF
	assign mf2_rom_en = mf2_en && (cpu_addr[15:13] == 3'b000);
	assign mf2_ram_en = mf2_en && (cpu_addr[15:13] == 3'b001);

endmodule

/* boot_addr_map.sv */
// Download to boot image address mapping, registered write port, upper ROM map
`timescale 1ns/1ps
`include "cpc_defs.svh"

module boot_addr_map (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  cpc_mem_pkg::load_kind_t     load_kind,
	input  logic                        model,
	input  logic [8:0]                  page,
	input  logic                        ioctl_wr,
	input  logic [`CPC_IOCTL_AW-1:0]    ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	output logic                        boot_wr,
	output cpc_mem_pkg::boot_addr_u     boot_addr,
	output logic [1:0]                  boot_bank,
	output logic [7:0]                  boot_dout,
	output logic [`CPC_ROM_MAP_N-1:0]   rom_map
);

	cpc_mem_pkg::boot_addr_u map_addr;
	logic [1:0]              map_bank;
	logic                    map_wr;
	logic [10:0]             block;		// 16 KB block of the download

	assign block = ioctl_addr[`CPC_IOCTL_AW-1:14];

	////////////////////////////////////////////////////////////////////////
	// Address map, 1st 4 MB OS/RAM/MF2, 2nd 4 MB upper ROMs
	always_comb begin
		map_wr          = ioctl_wr;
		map_addr.flat   = '1;
		map_addr.f.offset = ioctl_addr[13:0];
		map_bank        = 2'd0;
		case (load_kind)
			cpc_mem_pkg::load_rom: begin
				case (block)
					11'd0, 11'd4: {map_addr.f.upper, map_addr.f.page} = `CPC_SLOT_OS;
					11'd1, 11'd5: {map_addr.f.upper, map_addr.f.page} = `CPC_SLOT_BASIC;
					11'd2, 11'd6: {map_addr.f.upper, map_addr.f.page} = `CPC_SLOT_AMSDOS;
					11'd3, 11'd7: {map_addr.f.upper, map_addr.f.page} = `CPC_SLOT_MF2;
					default:      map_wr = 1'b0;
				endcase
				map_bank = (block >= 11'd4) ? 2'd1 : 2'd0;	// 664 set in bank 1
			end
			cpc_mem_pkg::load_ext: begin
				map_addr.f.upper = page[8];
				map_addr.f.page  = page[7:0] + ioctl_addr[21:14];	// Wraps at 256
				map_bank         = {1'b0, model};
			end
			default: map_wr = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boot_wr <= 1'b0;
			rom_map <= '0;
		end else begin
			boot_wr <= map_wr;
			if (map_wr && map_addr.f.upper)
				rom_map[map_addr.f.page] <= 1'b1;
		end
	end

	// Write payload
	always_ff @(posedge clk_sys) begin
		boot_addr <= map_addr;
		boot_bank <= map_bank;
		boot_dout <= ioctl_dout;
	end

endmodule

/* ext_page_decode.sv */
// Expansion ROM start page from the file extension, combo image page switch
`timescale 1ns/1ps
`include "cpc_defs.svh"

module ext_page_decode (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    load_start,
	input  cpc_mem_pkg::load_kind_t load_kind,
	input  logic [15:0]             ioctl_file_ext,
	input  logic                    ioctl_wr,
	input  logic [13:0]             ioctl_offset,
	output logic [8:0]              page
);

	logic       combo;		// Z0 image, second part still to come
	logic [4:0] hex_hi;
	logic [4:0] hex_lo;
	logic [8:0] ext_page;

	// {valid, value} of one extension character
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	always_comb begin
		hex_hi = hex_digit(ioctl_file_ext[15:8]);
		hex_lo = hex_digit(ioctl_file_ext[7:0]);
		ext_page = `CPC_PAGE_BAD;	// Bit 8 kept, single digits go high
		if (hex_hi[4]) ext_page[7:4] = hex_hi[3:0];
		if (hex_lo[4]) ext_page[3:0] = hex_lo[3:0];
		if (ioctl_file_ext == "ZZ" || ioctl_file_ext == "Z0")
			ext_page = 9'h000;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page  <= `CPC_PAGE_BAD;
			combo <= 1'b0;
		end else if (load_start) begin
			combo <= (load_kind == cpc_mem_pkg::load_ext) && (ioctl_file_ext == "Z0");
			if (load_kind == cpc_mem_pkg::load_ext)
				page <= ext_page;
		end else if (ioctl_wr && combo && (&ioctl_offset)) begin
			// Last byte of the first 16 KB, rest of the image goes upper
			page  <= `CPC_PAGE_COMBO_END;
			combo <= 1'b0;
		end
	end

endmodule

/* load_control.sv */
// Download kind decode, load start strobe, core reset and model latch
`timescale 1ns/1ps
`include "cpc_defs.svh"

module load_control (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  logic [7:0]              ioctl_index,
	input  logic                    reset_req,
	input  logic                    cpc664_sel,
	output cpc_mem_pkg::load_kind_t load_kind,
	output logic                    load_start,
	output logic                    core_reset,
	output logic                    model
);

	logic download_q;	// Download level one cycle back

	// Only ROM and expansion downloads touch the boot image
	always_comb begin
		load_kind = cpc_mem_pkg::load_none;
		if (ioctl_download) begin
			if (ioctl_index == `CPC_IDX_ROM)
				load_kind = cpc_mem_pkg::load_rom;
			else if (ioctl_index == `CPC_IDX_EXT)
				load_kind = cpc_mem_pkg::load_ext;
		end
	end

	assign load_start = ioctl_download & ~download_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
		end else begin
			download_q <= ioctl_download;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Core held in reset while the image changes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= reset_req | (load_kind != cpc_mem_pkg::load_none);
		end
	end

	// Model only changes while the core sits in reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model <= 1'b0;
		end else if (core_reset) begin
			model <= cpc664_sel;	// 1 selects the 664
		end
	end

endmodule

/* cpc_mf2_pkg.sv */
// Multiface mode enum and Multiface store address union
package cpc_mf2_pkg;

	// Menu setting for the Multiface
	typedef enum logic [1:0] {
		mode_enabled  = 2'd0,
		mode_hidden   = 2'd1,
		mode_disabled = 2'd2
	} mf2_mode_t;

	// Table view for pen colours and CRTC values
	typedef struct packed {
		logic [8:0] region;
		logic [3:0] slot;
	} store_fields_t;

	typedef union packed {
		logic [12:0]   flat;
		store_fields_t tbl;
	} store_addr_u;

endpackage

/* cpc_mem_pkg.sv */
// Download kind enum and boot image address union
`include "cpc_defs.svh"

package cpc_mem_pkg;

	// Active download as seen by the loader
	typedef enum logic [1:0] {
		load_none = 2'd0,
		load_rom  = 2'd1,
		load_ext  = 2'd2
	} load_kind_t;

	// 16 KB page view of a boot address
	typedef struct packed {
		logic       upper;     // Second 4 MB holds the upper ROMs
		logic [7:0] page;
		logic [13:0] offset;
	} boot_fields_t;

	typedef union packed {
		logic [`CPC_BOOT_AW-1:0] flat;
		boot_fields_t            f;
	} boot_addr_u;

endpackage

/* cpc_defs.svh */
// Widths, download indices, ROM slot pages, Multiface ports and store addresses
`ifndef CPC_DEFS_SVH
`define CPC_DEFS_SVH

////////////////////////////////////////////////////////////////////////
// Boot image and download widths
`define CPC_BOOT_AW         23      // 8 MB image, byte address
`define CPC_IOCTL_AW        25
`define CPC_ROM_MAP_N       256     // Upper ROM pages

// Host download indices
`define CPC_IDX_ROM         8'd0
`define CPC_IDX_EXT         8'd3

////////////////////////////////////////////////////////////////////////
// ROM slots as {upper half, page}
`define CPC_SLOT_OS         9'h000
`define CPC_SLOT_BASIC      9'h100
`define CPC_SLOT_AMSDOS     9'h107
`define CPC_SLOT_MF2        9'h0FF

`define CPC_PAGE_BAD        9'h1EE  // Unused page for malformed extensions
`define CPC_PAGE_COMBO_END  9'h1FF

////////////////////////////////////////////////////////////////////////
// Multiface Two
`define MF2_NMI_ADDR        16'h0066
`define MF2_HIDE_ADDR       16'h0065
`define MF2_CTRL_PORT       14'b11111110111010  // FEE8 and FEEA, cpu_addr[15:2]

// Register capture locations in Multiface RAM
`define MF2_ST_PEN_IDX      13'h1FCF
`define MF2_ST_BORDER       13'h1FDF
`define MF2_ST_PEN_BASE     9'h1F9
`define MF2_ST_MODE         13'h1FEF
`define MF2_ST_BANK         13'h1FFF
`define MF2_ST_CRTC_SEL     13'h1CFF
`define MF2_ST_CRTC_BASE    9'h1DB
`define MF2_ST_PPI          13'h17FF
`define MF2_ST_UROM         13'h1AAC

`endif
